/* rtl/core_defines.svh */
// Core data width, memory depths and reset PC
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

////////////////////////////////////////////////////////////
// Datapath

`define XLEN      64

////////////////////////////////////////////////////////////
// Memories

`define IMEM_AW   8   // Words, 256 instructions
`define DMEM_AW   7   // Doublewords, 1 KiB

////////////////////////////////////////////////////////////
// Boot

`define RESET_PC  64'h0

`endif

/* rtl/core_pkg.sv */
// Opcode, ALU, branch, writeback and run-state enums; decoded control and operand structs
`default_nettype none

`include "core_defines.svh"

package core_pkg;

  // RV64I major opcodes in use
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_op     = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b   // LUI
  } alu_op_e;

  typedef enum logic [3:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_jal,
    br_jalr
  } br_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_link
  } wb_sel_e;

  typedef enum logic {
    st_running,
    st_halted
  } run_state_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       a_is_pc;    // AUIPC
    logic       b_is_imm;
    br_op_e     br_op;
    logic       mem_rd;
    logic       mem_wr;
    logic       mem_dword;  // LD/SD
    logic       rf_wen;
    wb_sel_e    wb_sel;
    logic [4:0] rd;
  } dec_ctrl_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
  } operands_t;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
// Program counter, run/halt FSM and instruction memory with load port
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_unit
  import core_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic [`XLEN-1:0]    i_next_pc,
  input  logic                i_halt_req,
  input  logic                i_imem_we,
  input  logic [`IMEM_AW-1:0] i_imem_addr,
  input  logic [31:0]         i_imem_wdata,
  output logic [`XLEN-1:0]    o_pc,
  output logic [31:0]         o_inst,
  output logic                o_running
);

  run_state_e       state;
  logic [`XLEN-1:0] pc;
  logic [31:0]      imem [0:(1 << `IMEM_AW)-1];

  ////////////////////////////////////////////////////////////
  // PC and run state

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= st_running;
      pc    <= `RESET_PC;
    end else if (state == st_running) begin
      if (i_halt_req) begin
        state <= st_halted;   // PC stays on the halting instruction
      end else begin
        pc <= i_next_pc;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Instruction memory

  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr] <= i_imem_wdata;
    end
  end

  assign o_pc      = pc;
  assign o_inst    = imem[pc[`IMEM_AW+1:2]];   // Word index, low bits ignored
  assign o_running = (state == st_running);

endmodule

`default_nettype wire

/* rtl/decode_unit.sv */
// Instruction decoder, immediate generator and 32x64 register file
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module decode_unit
  import core_pkg::*;
(
  input  logic             i_clk,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [31:0]      i_inst,
  input  logic             i_wb_en,
  input  logic [4:0]       i_wb_rd,
  input  logic [`XLEN-1:0] i_wb_data,
  output dec_ctrl_t        o_ctrl,
  output operands_t        o_ops,
  output logic             o_halt_req
);

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm;
  logic             halt;
  dec_ctrl_t        ctrl;
  logic [`XLEN-1:0] regs [0:31];

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];

  ////////////////////////////////////////////////////////////
  // Immediates

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // Shared by OP and OP-IMM
  function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  ////////////////////////////////////////////////////////////
  // Control decode

  always_comb begin
    ctrl    = '0;
    ctrl.rd = i_inst[11:7];
    imm     = '0;
    halt    = 1'b0;
    case (opcode)
      op_lui: begin
        ctrl.alu_op   = alu_pass_b;
        ctrl.b_is_imm = 1'b1;
        ctrl.rf_wen   = 1'b1;
        imm           = imm_u;
      end
      op_auipc: begin
        ctrl.a_is_pc  = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.rf_wen   = 1'b1;
        imm           = imm_u;
      end
      op_jal: begin
        ctrl.br_op  = br_jal;
        ctrl.rf_wen = 1'b1;
        ctrl.wb_sel = wb_link;
        imm         = imm_j;
      end
      op_jalr: begin
        ctrl.br_op  = br_jalr;
        ctrl.rf_wen = 1'b1;
        ctrl.wb_sel = wb_link;
        imm         = imm_i;
        halt        = (funct3 != 3'b000);
      end
      op_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000:  ctrl.br_op = br_beq;
          3'b001:  ctrl.br_op = br_bne;
          3'b100:  ctrl.br_op = br_blt;
          3'b101:  ctrl.br_op = br_bge;
          3'b110:  ctrl.br_op = br_bltu;
          3'b111:  ctrl.br_op = br_bgeu;
          default: halt = 1'b1;
        endcase
      end
      op_load: begin
        ctrl.mem_rd    = 1'b1;
        ctrl.mem_dword = funct3[0];
        ctrl.b_is_imm  = 1'b1;
        ctrl.rf_wen    = 1'b1;
        ctrl.wb_sel    = wb_load;
        imm            = imm_i;
        halt           = (funct3[2:1] != 2'b01);   // LW and LD only
      end
      op_store: begin
        ctrl.mem_wr    = 1'b1;
        ctrl.mem_dword = funct3[0];
        ctrl.b_is_imm  = 1'b1;
        imm            = imm_s;
        halt           = (funct3[2:1] != 2'b01);
      end
      op_imm: begin
        ctrl.alu_op   = funct_to_alu(funct3, (funct3 == 3'b101) && i_inst[30]);
        ctrl.b_is_imm = 1'b1;
        ctrl.rf_wen   = 1'b1;
        imm           = imm_i;
        // 6-bit shamt, funct6 above it
        if (funct3 == 3'b001) begin
          halt = (i_inst[31:26] != 6'b0);
        end else if (funct3 == 3'b101) begin
          halt = i_inst[31] || (i_inst[29:26] != 4'b0);
        end
      end
      op_op: begin
        ctrl.alu_op = funct_to_alu(funct3, funct7[5]);
        ctrl.rf_wen = 1'b1;
        halt        = ({funct7[6], funct7[4:0]} != 6'b0) ||
                      (funct7[5] && (funct3 != 3'b000) && (funct3 != 3'b101));
      end
      op_system: halt = 1'b1;   // EBREAK; other SYSTEM encodings unsupported
      default:   halt = 1'b1;
    endcase
    if (halt) begin
      ctrl.rf_wen = 1'b0;
      ctrl.mem_wr = 1'b0;
      ctrl.mem_rd = 1'b0;
      ctrl.br_op  = br_none;
    end
  end

  ////////////////////////////////////////////////////////////
  // Register file

  always_ff @(posedge i_clk) begin
    if (i_wb_en) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  assign o_ops.pc       = i_pc;
  assign o_ops.rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign o_ops.rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];
  assign o_ops.imm      = imm;

  assign o_ctrl     = ctrl;
  assign o_halt_req = halt;

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
// ALU with operand A/B selection
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_unit
  import core_pkg::*;
(
  input  dec_ctrl_t        i_ctrl,
  input  operands_t        i_ops,
  output logic [`XLEN-1:0] o_alu_result
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [5:0]       shamt;
  logic             lt_s;
  logic             lt_u;

  assign op_a  = i_ctrl.a_is_pc  ? i_ops.pc  : i_ops.rs1_data;
  assign op_b  = i_ctrl.b_is_imm ? i_ops.imm : i_ops.rs2_data;
  assign shamt = op_b[5:0];   // RV64 shift amount

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  always_comb begin
    case (i_ctrl.alu_op)
      alu_add:    o_alu_result = op_a + op_b;
      alu_sub:    o_alu_result = op_a - op_b;
      alu_sll:    o_alu_result = op_a << shamt;
      alu_slt:    o_alu_result = {{(`XLEN-1){1'b0}}, lt_s};
      alu_sltu:   o_alu_result = {{(`XLEN-1){1'b0}}, lt_u};
      alu_xor:    o_alu_result = op_a ^ op_b;
      alu_srl:    o_alu_result = op_a >> shamt;
      alu_sra:    o_alu_result = $unsigned($signed(op_a) >>> shamt);
      alu_or:     o_alu_result = op_a | op_b;
      alu_and:    o_alu_result = op_a & op_b;
      alu_pass_b: o_alu_result = op_b;
      default:    o_alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/branch_unit.sv */
// Branch compare, jump targets and next-PC select
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module branch_unit
  import core_pkg::*;
(
  input  dec_ctrl_t        i_ctrl,
  input  operands_t        i_ops,
  output logic [`XLEN-1:0] o_next_pc,
  output logic [`XLEN-1:0] o_link
);

  logic             eq;
  logic             lt;
  logic             ltu;
  logic             taken;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] pc_target;
  logic [`XLEN-1:0] jalr_sum;

  // Own comparator, independent of the ALU
  assign eq  = (i_ops.rs1_data == i_ops.rs2_data);
  assign lt  = $signed(i_ops.rs1_data) < $signed(i_ops.rs2_data);
  assign ltu = i_ops.rs1_data < i_ops.rs2_data;

  always_comb begin
    case (i_ctrl.br_op)
      br_beq:  taken = eq;
      br_bne:  taken = !eq;
      br_blt:  taken = lt;
      br_bge:  taken = !lt;
      br_bltu: taken = ltu;
      br_bgeu: taken = !ltu;
      br_jal:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4  = i_ops.pc + `XLEN'd4;
  assign pc_target = i_ops.pc + i_ops.imm;
  assign jalr_sum  = i_ops.rs1_data + i_ops.imm;

  assign o_next_pc = (i_ctrl.br_op == br_jalr) ? {jalr_sum[`XLEN-1:1], 1'b0} :
                     taken                     ? pc_target : pc_plus4;
  assign o_link    = pc_plus4;

endmodule

`default_nettype wire

/* rtl/mem_unit.sv */
// Data memory with word/doubleword access and writeback select
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module mem_unit
  import core_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_running,
  input  dec_ctrl_t        i_ctrl,
  input  operands_t        i_ops,
  input  logic [`XLEN-1:0] i_alu_result,
  input  logic [`XLEN-1:0] i_link,
  output logic             o_wb_en,
  output logic [4:0]       o_wb_rd,
  output logic [`XLEN-1:0] o_wb_data
);

  logic [`DMEM_AW-1:0] idx;
  logic                hi_half;
  logic [`XLEN-1:0]    dmem [0:(1 << `DMEM_AW)-1];
  logic [`XLEN-1:0]    rd_dword;
  logic [31:0]         rd_word;
  logic [`XLEN-1:0]    load_data;

  assign idx     = i_alu_result[`DMEM_AW+2:3];
  assign hi_half = i_alu_result[2];

  ////////////////////////////////////////////////////////////
  // Store

  always_ff @(posedge i_clk) begin
    if (i_running && i_ctrl.mem_wr) begin
      if (i_ctrl.mem_dword) begin
        dmem[idx] <= i_ops.rs2_data;
      end else if (hi_half) begin
        dmem[idx][`XLEN-1:32] <= i_ops.rs2_data[31:0];
      end else begin
        dmem[idx][31:0] <= i_ops.rs2_data[31:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Load and writeback

  assign rd_dword = dmem[idx];
  assign rd_word  = hi_half ? rd_dword[`XLEN-1:32] : rd_dword[31:0];

  assign load_data = !i_ctrl.mem_rd   ? '0 :
                     i_ctrl.mem_dword ? rd_dword :
                     {{(`XLEN-32){rd_word[31]}}, rd_word};   // LW sign-extends

  always_comb begin
    case (i_ctrl.wb_sel)
      wb_load: o_wb_data = load_data;
      wb_link: o_wb_data = i_link;
      default: o_wb_data = i_alu_result;
    endcase
  end

  assign o_wb_en = i_running && i_ctrl.rf_wen && (i_ctrl.rd != 5'd0);
  assign o_wb_rd = i_ctrl.rd;

endmodule

`default_nettype wire

/* rtl/core_top.sv */
// Single-cycle RV64I core top level with retire trace
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_top
  import core_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_imem_we,
  input  logic [`IMEM_AW-1:0] i_imem_addr,
  input  logic [31:0]         i_imem_wdata,
  output logic [`XLEN-1:0]    o_pc,
  output logic                o_retire,
  output logic                o_wb_en,
  output logic [4:0]          o_wb_rd,
  output logic [`XLEN-1:0]    o_wb_data,
  output logic                o_halted
);

  logic [`XLEN-1:0] pc;
  logic [31:0]      inst;
  logic             running;
  logic             halt_req;
  dec_ctrl_t        ctrl;
  operands_t        ops;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] next_pc;
  logic [`XLEN-1:0] link;
  logic             wb_en;
  logic [4:0]       wb_rd;
  logic [`XLEN-1:0] wb_data;

  fetch_unit u_fetch (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_next_pc    (next_pc),
    .i_halt_req   (halt_req),
    .i_imem_we    (i_imem_we),
    .i_imem_addr  (i_imem_addr),
    .i_imem_wdata (i_imem_wdata),
    .o_pc         (pc),
    .o_inst       (inst),
    .o_running    (running)
  );

  decode_unit u_decode (
    .i_clk      (i_clk),
    .i_pc       (pc),
    .i_inst     (inst),
    .i_wb_en    (wb_en),
    .i_wb_rd    (wb_rd),
    .i_wb_data  (wb_data),
    .o_ctrl     (ctrl),
    .o_ops      (ops),
    .o_halt_req (halt_req)
  );

  // ALU and branch unit see the same operands
  exec_unit u_exec (
    .i_ctrl       (ctrl),
    .i_ops        (ops),
    .o_alu_result (alu_result)
  );

  branch_unit u_branch (
    .i_ctrl    (ctrl),
    .i_ops     (ops),
    .o_next_pc (next_pc),
    .o_link    (link)
  );

  mem_unit u_mem (
    .i_clk        (i_clk),
    .i_running    (running),
    .i_ctrl       (ctrl),
    .i_ops        (ops),
    .i_alu_result (alu_result),
    .i_link       (link),
    .o_wb_en      (wb_en),
    .o_wb_rd      (wb_rd),
    .o_wb_data    (wb_data)
  );

  assign o_pc      = pc;
  assign o_retire  = running && !halt_req;   // Halting instruction never retires
  assign o_wb_en   = wb_en;
  assign o_wb_rd   = wb_rd;
  assign o_wb_data = wb_data;
  assign o_halted  = !running;

endmodule

`default_nettype wire

/* bench/core_properties.sv */
// Concurrent checks on the retire trace and halt state, bound to core_top
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_properties (
  input logic             i_clk,
  input logic             i_rst_n,
  input logic [`XLEN-1:0] i_pc,
  input logic             i_retire,
  input logic             i_wb_en,
  input logic [4:0]       i_wb_rd,
  input logic             i_halted
);

  int unsigned fail_count = 0;   // Read by the testbench at the end of the run

  ////////////////////////////////////////////////////////////
  // Retire and halt

  // A running cycle without retire is the halting one, and halt holds until reset
  a_halt_entry: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_halted || !i_retire) |=> i_halted)
  else begin
    $error("Halted state not entered or not held after a cycle without retire");
    fail_count++;
  end

  // Writeback only from a retiring instruction and never to x0
  a_wb_en_retire: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wb_en |-> (i_retire && (i_wb_rd != 5'd0)))
  else begin
    $error("Writeback enable without retire or with rd of x0");
    fail_count++;
  end

  a_pc_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_halted |=> $stable(i_pc))
  else begin
    $error("PC moved while the core is halted");
    fail_count++;
  end

endmodule

bind core_top core_properties u_props (
  .i_clk    (i_clk),
  .i_rst_n  (i_rst_n),
  .i_pc     (o_pc),
  .i_retire (o_retire),
  .i_wb_en  (o_wb_en),
  .i_wb_rd  (o_wb_rd),
  .i_halted (o_halted)
);

`default_nettype wire

/* bench/core_tb.sv */
// Testbench: clock, reset, LFSR, program builder, retire checker and directed tests
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_tb;

  localparam int          drive_delay = 2;
  localparam int          run_limit   = 1000;   // Cycles until halt
  localparam logic [31:0] lfsr_seed   = 32'h875da736;
  localparam logic [31:0] ebreak_inst = 32'h00100073;

  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  // {alt, funct3} of ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
  localparam logic [3:0] reg_ops [0:9] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3,
                                           4'h4, 4'h5, 4'hd, 4'h6, 4'h7};

  typedef struct packed {
    logic [63:0] pc;
    logic        wb_en;
    logic [4:0]  rd;
    logic [63:0] data;
  } retire_t;

  logic                clk;
  logic                rst_n;
  logic                imem_we;
  logic [`IMEM_AW-1:0] imem_addr;
  logic [31:0]         imem_wdata;
  logic [63:0]         pc;
  logic                retire;
  logic                wb_en;
  logic [4:0]          wb_rd;
  logic [63:0]         wb_data;
  logic                halted;

  logic [31:0] lfsr;
  logic [31:0] prog [$];
  retire_t     exp_q [$];
  logic [63:0] xreg [0:31];        // Architectural register model
  logic [63:0] mem_model [0:127];  // Data memory model with one entry per doubleword
  logic [63:0] halt_pc;

  core_top dut0 (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_imem_we    (imem_we),
    .i_imem_addr  (imem_addr),
    .i_imem_wdata (imem_wdata),
    .o_pc         (pc),
    .o_retire     (retire),
    .o_wb_en      (wb_en),
    .o_wb_rd      (wb_rd),
    .o_wb_data    (wb_data),
    .o_halted     (halted)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Error reporting and random numbers

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
      fail_now($sformatf("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);   // Galois step
      r    = {r[62:0], b};
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // ISA rules and encoders

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [63:0] isa_alu(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    logic [5:0]         sh;
    sa = a;
    sh = b[5:0];
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'b011:  return (a < b) ? 64'd1 : 64'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return sa >>> sh;
        return a >> sh;
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  ////////////////////////////////////////////////////////////
  // Program builder with the expected trace kept alongside

  function automatic logic [63:0] place_addr();
    return 64'(prog.size()) * 64'd4;
  endfunction

  task automatic clear_program();
    prog.delete();
    exp_q.delete();
  endtask

  task automatic place(input logic [31:0] inst);
    prog.push_back(inst);
  endtask

  task automatic place_halt(input logic [31:0] inst);
    halt_pc = place_addr();
    place(inst);
  endtask

  task automatic emit(input logic [31:0] inst, input logic wb, input logic [4:0] rd,
                      input logic [63:0] data);
    retire_t r;
    r.pc    = place_addr();
    r.wb_en = wb && (rd != 5'd0);   // x0 is never written
    r.rd    = rd;
    r.data  = data;
    exp_q.push_back(r);
    if (r.wb_en) xreg[rd] = data;
    place(inst);
  endtask

  task automatic op_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    logic alt;
    alt = (f3 == 3'b101) && imm[10];
    emit(enc_i(imm, rs1, f3, rd, opc_imm), 1'b1, rd, isa_alu(f3, alt, xreg[rs1], sext12(imm)));
  endtask

  task automatic op_reg(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2);
    emit(enc_r({1'b0, op[3], 5'b0}, rs2, rs1, op[2:0], rd, opc_op), 1'b1, rd,
         isa_alu(op[2:0], op[3], xreg[rs1], xreg[rs2]));
  endtask

  task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
    emit({imm, rd, opc_lui}, 1'b1, rd, {{32{imm[19]}}, imm, 12'b0});
  endtask

  task automatic auipc(input logic [4:0] rd, input logic [19:0] imm);
    emit({imm, rd, opc_auipc}, 1'b1, rd, place_addr() + {{32{imm[19]}}, imm, 12'b0});
  endtask

  // Upper word by LUI and ADDI, then the low word shifted in 11, 11 and 10 bits at a time
  task automatic load_const(input logic [4:0] rd, input logic [63:0] value);
    logic [31:0] hi;
    logic [31:0] up;
    hi = value[63:32];
    up = (hi + 32'h800) >> 12;
    lui(rd, up[19:0]);
    op_imm(3'b000, rd, rd, hi[11:0]);
    op_imm(3'b001, rd, rd, 12'd11);
    op_imm(3'b110, rd, rd, {1'b0, value[31:21]});
    op_imm(3'b001, rd, rd, 12'd11);
    op_imm(3'b110, rd, rd, {1'b0, value[20:10]});
    op_imm(3'b001, rd, rd, 12'd10);
    op_imm(3'b110, rd, rd, {2'b0, value[9:0]});
  endtask

  task automatic store(input logic dword, input logic [4:0] rs2, input logic [4:0] rs1,
                       input logic [11:0] off);
    logic [63:0] addr;
    logic [63:0] v;
    addr = xreg[rs1] + sext12(off);
    v    = xreg[rs2];
    if (dword) mem_model[addr[9:3]] = v;
    else if (addr[2]) mem_model[addr[9:3]][63:32] = v[31:0];
    else mem_model[addr[9:3]][31:0] = v[31:0];
    emit(enc_s(off, rs2, rs1, {2'b01, dword}), 1'b0, 5'd0, 64'd0);
  endtask

  task automatic load(input logic dword, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [11:0] off);
    logic [63:0] addr;
    logic [63:0] d;
    logic [31:0] w;
    addr = xreg[rs1] + sext12(off);
    d    = mem_model[addr[9:3]];
    w    = addr[2] ? d[63:32] : d[31:0];
    emit(enc_i(off, rs1, {2'b01, dword}, rd, opc_load), 1'b1, rd,
         dword ? d : {{32{w[31]}}, w});
  endtask

  // Fillers between a jump and its target; skipped ones never retire
  task automatic skip_or_run(input logic skipped, input int n);
    for (int i = 0; i < n; i++) begin
      if (skipped) place(enc_i(12'd1, 5'd31, 3'b000, 5'd31, opc_imm));
      else op_imm(3'b000, 5'd31, 5'd31, 12'd1);
    end
  endtask

  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [63:0] a;
    logic [63:0] b;
    logic        taken;
    int          n;
    a = xreg[rs1];
    b = xreg[rs2];
    case (f3)
      3'b000:  taken = (a == b);
      3'b001:  taken = (a != b);
      3'b100:  taken = ($signed(a) < $signed(b));
      3'b101:  taken = ($signed(a) >= $signed(b));
      3'b110:  taken = (a < b);
      default: taken = (a >= b);
    endcase
    n = int'(rand_bits(2)) + 1;
    emit(enc_b(13'(4 * (n + 1)), rs2, rs1, f3), 1'b0, 5'd0, 64'd0);
    skip_or_run(taken, n);
  endtask

  task automatic jump_and_link(input logic [4:0] rd);
    int n;
    n = int'(rand_bits(2)) + 1;
    emit(enc_j(21'(4 * (n + 1)), rd), 1'b1, rd, place_addr() + 64'd4);
    skip_or_run(1'b1, n);
  endtask

  // AUIPC gives the base, odd offset checks that bit 0 of the target is cleared
  task automatic jump_register(input logic [4:0] rd, input logic [4:0] base);
    logic [63:0] p;
    int          n;
    p = place_addr();
    n = int'(rand_bits(2)) + 1;
    auipc(base, 20'h0);
    emit(enc_i(12'(8 + 4 * n + 1), base, 3'b000, rd, opc_jalr), 1'b1, rd, p + 64'd8);
    skip_or_run(1'b1, n);
  endtask

  ////////////////////////////////////////////////////////////
  // Reset, load and trace check

  task automatic reset_and_load();
    int n;
    int i;
    n = (prog.size() > 16) ? prog.size() : 16;
    @(posedge clk);
    #drive_delay;
    rst_n = 1'b0;
    for (i = 0; i < n; i++) begin
      imem_we    = (i < prog.size());
      imem_addr  = `IMEM_AW'(i);
      imem_wdata = (i < prog.size()) ? prog[i] : 32'h0;
      @(posedge clk);
      #drive_delay;
    end
    imem_we = 1'b0;
    rst_n   = 1'b1;
  endtask

  task automatic check_retire(input retire_t r, input int k);
    check_eq(pc, r.pc, $sformatf("PC of retire %0d", k));
    check_eq(64'(wb_en), 64'(r.wb_en), $sformatf("wb enable of retire %0d", k));
    if (r.wb_en) begin
      check_eq(64'(wb_rd), 64'(r.rd), $sformatf("wb rd of retire %0d", k));
      check_eq(wb_data, r.data, $sformatf("wb data of retire %0d", k));
    end
  endtask

  task automatic run_program();
    int          cycles;
    int          k;
    logic [63:0] held_pc;
    reset_and_load();
    cycles = 0;
    k      = 0;
    @(negedge clk);
    while (halted !== 1'b1) begin
      assert (cycles < run_limit) else fail_now("Timeout: core did not halt");
      if (retire) begin
        assert (k < exp_q.size()) else fail_now("Core retired more instructions than expected");
        check_retire(exp_q[k], k);
        k++;
      end
      cycles++;
      @(negedge clk);
    end
    assert (k == exp_q.size()) else fail_now("Core halted before retiring the whole program");
    check_eq(pc, halt_pc, "PC after halt");
    held_pc = pc;
    repeat (20) begin
      @(negedge clk);
      assert (!retire) else fail_now("Retire pulse seen while halted");
      check_eq(pc, held_pc, "PC while halted");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests

  task automatic imm_arith_test();
    clear_program();
    load_const(5'd1, rand_bits(64));
    load_const(5'd2, rand_bits(64));
    repeat (4) begin
      op_imm(3'b000, 5'd3, 5'd1, 12'(rand_bits(12)));
      op_imm(3'b100, 5'd4, 5'd2, 12'(rand_bits(12)));
      op_imm(3'b110, 5'd5, 5'd1, 12'(rand_bits(12)));
      op_imm(3'b111, 5'd6, 5'd2, 12'(rand_bits(12)));
      op_imm(3'b010, 5'd7, 5'd1, 12'(rand_bits(12)));
      op_imm(3'b011, 5'd8, 5'd2, 12'(rand_bits(12)));
      op_imm(3'b001, 5'd9, 5'd1, {6'b0, 6'(rand_bits(6))});
      op_imm(3'b101, 5'd10, 5'd2, {6'b0, 6'(rand_bits(6))});
      op_imm(3'b101, 5'd11, 5'd2, {6'b010000, 6'(rand_bits(6))});   // SRAI
      op_imm(3'b000, 5'd1, 5'd11, 12'(rand_bits(12)));
      op_imm(3'b100, 5'd2, 5'd9, 12'(rand_bits(12)));
    end
    place_halt(ebreak_inst);
    run_program();
  endtask

  task automatic reg_alu_test();
    clear_program();
    load_const(5'd5, rand_bits(64));
    load_const(5'd6, rand_bits(64));
    load_const(5'd7, {1'b1, 63'(rand_bits(63))});
    for (int i = 0; i < 10; i++) begin
      op_reg(reg_ops[i], 5'(8 + i), 5'd5, 5'd6);
      op_reg(reg_ops[i], 5'(18 + i), 5'd7, 5'd5);
    end
    op_reg(4'h0, 5'd0, 5'd5, 5'd6);   // Writes to x0 are dropped
    op_imm(3'b000, 5'd0, 5'd5, 12'(rand_bits(12)));
    lui(5'd0, 20'(rand_bits(20)));
    op_reg(4'h0, 5'd28, 5'd0, 5'd5);
    op_reg(4'h6, 5'd29, 5'd0, 5'd0);
    op_reg(4'h2, 5'd30, 5'd5, 5'd5);
    place_halt(ebreak_inst);
    run_program();
  endtask

  task automatic load_store_test();
    clear_program();
    op_imm(3'b000, 5'd10, 5'd0, {3'b0, 6'(rand_bits(6)), 3'b000});
    load_const(5'd11, rand_bits(64));
    load_const(5'd12, {32'(rand_bits(32)), 1'b1, 31'(rand_bits(31))});
    load_const(5'd13, {32'(rand_bits(32)), 1'b0, 31'(rand_bits(31))});
    store(1'b1, 5'd11, 5'd10, 12'd0);
    load(1'b1, 5'd14, 5'd10, 12'd0);
    store(1'b0, 5'd12, 5'd10, 12'd8);
    load(1'b0, 5'd15, 5'd10, 12'd8);
    store(1'b0, 5'd13, 5'd10, 12'd12);
    load(1'b0, 5'd16, 5'd10, 12'd12);
    load(1'b1, 5'd17, 5'd10, 12'd8);
    store(1'b1, 5'd11, 5'd10, 12'd16);
    store(1'b0, 5'd12, 5'd10, 12'd20);   // Upper half only
    load(1'b1, 5'd18, 5'd10, 12'd16);
    store(1'b1, 5'd11, 5'd10, 12'd24);
    store(1'b0, 5'd13, 5'd10, 12'd24);   // Lower half only
    load(1'b1, 5'd19, 5'd10, 12'd24);
    load(1'b0, 5'd20, 5'd10, 12'd4);
    place_halt(ebreak_inst);
    run_program();
  endtask

  task automatic control_flow_test();
    clear_program();
    op_imm(3'b000, 5'd31, 5'd0, 12'h0);
    load_const(5'd1, {1'b0, 63'(rand_bits(63))});   // Positive
    load_const(5'd2, {1'b1, 63'(rand_bits(63))});   // Negative, large unsigned
    branch(3'b000, 5'd1, 5'd1);
    branch(3'b000, 5'd1, 5'd2);
    branch(3'b001, 5'd1, 5'd2);
    branch(3'b001, 5'd2, 5'd2);
    branch(3'b100, 5'd2, 5'd1);
    branch(3'b100, 5'd1, 5'd2);
    branch(3'b101, 5'd1, 5'd2);
    branch(3'b101, 5'd2, 5'd1);
    branch(3'b110, 5'd1, 5'd2);
    branch(3'b110, 5'd2, 5'd1);
    branch(3'b111, 5'd2, 5'd1);
    branch(3'b111, 5'd1, 5'd2);
    jump_and_link(5'd5);
    jump_register(5'd7, 5'd6);
    auipc(5'd8, 20'(rand_bits(20)));
    place_halt(ebreak_inst);
    run_program();
  endtask

  task automatic halt_test();
    clear_program();
    op_imm(3'b000, 5'd1, 5'd0, 12'(rand_bits(12)));
    op_imm(3'b000, 5'd2, 5'd1, 12'(rand_bits(12)));
    place_halt(ebreak_inst);
    run_program();
    clear_program();
    op_imm(3'b000, 5'd3, 5'd0, 12'(rand_bits(12)));
    place_halt(enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, opc_op));   // MUL is not supported
    run_program();
    run_program();   // Reset after halt starts again from address 0
    clear_program();
    place_halt(32'hffff_ffff);
    run_program();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    rst_n      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    lfsr       = lfsr_seed;
    halt_pc    = '0;
    for (int i = 0; i < 32; i++) begin
      xreg[i] = '0;
    end
    imm_arith_test();
    reg_alu_test();
    load_store_test();
    control_flow_test();
    halt_test();
    if (dut0.u_props.fail_count != 0) begin
      fail_now("A concurrent assertion on core_top failed during the run");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/exec_unit.sv
rtl/branch_unit.sv
rtl/mem_unit.sv
rtl/core_top.sv
bench/core_properties.sv
bench/core_tb.sv
